// ==== logic/board_pkg.sv ====
/*
 * Board, column height and report types
 */
`default_nettype none
`include "tetris_defines.svh"

package board_pkg;

	// Bit c is column c
	typedef logic [`TETRIS_COLS-1:0] row_t;

	// Row 1 at the bottom
	typedef row_t [`TETRIS_ROWS:1] board_t;

	// Zero means an empty column
	typedef logic [4:0] height_t;
	typedef height_t [`TETRIS_COLS-1:0] heights_t;

	typedef struct packed {
		logic [`TETRIS_VISIBLE*`TETRIS_COLS-1:0] tetris;
		logic [3:0] score;
		logic fail;
	} report_t;

endpackage

`default_nettype wire

// ==== logic/board_store.sv ====
/*
 * Game board register with piece placement, full-row compaction and clear
 */
`timescale 1ns/1ps
`default_nettype none
`include "tetris_defines.svh"

module board_store (
	input logic clk,
	input logic rst_n,
	input piece_pkg::piece_cells_t cells,
	input logic place,
	input logic settle,
	input logic compact,
	input logic game_clear,
	output board_pkg::board_t board,
	output logic [2:0] clear_count
);
	import board_pkg::*;

	logic [`TETRIS_ROWS:1] full_rows;
	logic [`TETRIS_ROWS:1] kill_mask;
	board_t packed_board;
	logic [4:0] dst;

	// ----------------------------------------
	// Full-row detection
	// ----------------------------------------

	always_comb begin
		clear_count = '0;
		for (int r = 1; r <= `TETRIS_ROWS; r++) begin
			full_rows[r] = &board[r];
			clear_count = clear_count + {2'b00, full_rows[r]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			kill_mask <= '0;
		else if (settle)
			kill_mask <= full_rows;
	end

	// Surviving rows slide down in order, empty rows fill the top
	always_comb begin
		packed_board = '0;
		dst = 5'd1;
		for (int r = 1; r <= `TETRIS_ROWS; r++) begin
			if (!kill_mask[r]) begin
				packed_board[dst] = board[r];
				dst = dst + 5'd1;
			end
		end
	end

	// ----------------------------------------
	// Board register
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			board <= '0;
		end else if (game_clear) begin
			board <= '0;
		end else if (compact) begin
			board <= packed_board;
		end else if (place) begin
			for (int i = 0; i < `TETRIS_PIECE_CELLS; i++)
				board[cells[i].row][cells[i].col] <= 1'b1;
		end
	end

	a_place_compact: assert property (@(posedge clk) disable iff (!rst_n)
		!(place && compact));

	for (genvar i = 0; i < `TETRIS_PIECE_CELLS; i++) begin : g_cell
		a_cell_row: assert property (@(posedge clk) disable iff (!rst_n)
			place |-> (cells[i].row >= 5'd1 && cells[i].row <= `TETRIS_ROWS));
	end

endmodule

`default_nettype wire

// ==== logic/column_height.sv ====
/*
 * Registered stack height of every board column
 */
`timescale 1ns/1ps
`default_nettype none
`include "tetris_defines.svh"

module column_height (
	input logic clk,
	input logic rst_n,
	input board_pkg::board_t board,
	output board_pkg::heights_t heights
);
	import board_pkg::*;

	heights_t top;

	// Highest occupied row wins
	always_comb begin
		for (int c = 0; c < `TETRIS_COLS; c++) begin
			top[c] = '0;
			for (int r = 1; r <= `TETRIS_ROWS; r++) begin
				if (board[r][c])
					top[c] = height_t'(r);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			heights <= '0;
		else
			heights <= top;
	end

	for (genvar c = 0; c < `TETRIS_COLS; c++) begin : g_range
		a_height_range: assert property (@(posedge clk) disable iff (!rst_n)
			heights[c] <= `TETRIS_ROWS);
	end

endmodule

`default_nettype wire

// ==== logic/piece_drop.sv ====
/*
 * Landing base and absolute cells of a dropped piece
 * Works from the column heights and the shape offset tables
 */
`timescale 1ns/1ps
`default_nettype none
`include "tetris_defines.svh"

module piece_drop (
	input board_pkg::heights_t heights,
	input piece_pkg::shape_t shape,
	input logic [2:0] position,
	output piece_pkg::piece_cells_t cells
);
	import piece_pkg::*;

	// ----------------------------------------
	// Landing base
	// ----------------------------------------

	logic [2:0] col;
	logic signed [6:0] cand;
	logic signed [6:0] base;

	// Each covered column asks for height - bottom + 1
	// Every shape has a column with bottom 0, so base ends at 1 or more
	always_comb begin
		col = position;
		cand = '0;
		base = '0;
		for (int c = 0; c < 4; c++) begin
			col = position + 3'(c);
			if (c < SHAPE_WIDTH[shape]) begin
				cand = $signed({2'b00, heights[col]})
					- $signed({5'b00000, COL_BOTTOM[shape][c]}) + 7'sd1;
				if (cand > base)
					base = cand;
			end
		end
	end

	// ----------------------------------------
	// Absolute cells
	// ----------------------------------------

	always_comb begin
		for (int i = 0; i < `TETRIS_PIECE_CELLS; i++) begin
			cells[i].col = position + {1'b0, CELL_COL[shape][i]};
			cells[i].row = base[4:0] + {3'b000, CELL_ROW[shape][i]};
		end
	end

endmodule

`default_nettype wire

// ==== logic/piece_pkg.sv ====
/*
 * Piece shapes, cell offset tables and the placed-cell types
 */
`default_nettype none
`include "tetris_defines.svh"

package piece_pkg;

	typedef logic [2:0] shape_t;
	typedef logic [1:0] ofs_t;

	// One occupied cell on the board
	typedef struct packed {
		logic [2:0] col;
		logic [4:0] row;
	} cell_t;

	typedef cell_t [`TETRIS_PIECE_CELLS-1:0] piece_cells_t;

	// Cell offsets from the lower-left corner, indexed by shape then cell
	localparam ofs_t CELL_COL [8][`TETRIS_PIECE_CELLS] = '{
		'{0, 1, 0, 1}, '{0, 0, 0, 0}, '{0, 1, 2, 3}, '{0, 1, 1, 1},
		'{0, 0, 1, 2}, '{0, 0, 0, 1}, '{0, 0, 1, 1}, '{0, 1, 1, 2}};
	localparam ofs_t CELL_ROW [8][`TETRIS_PIECE_CELLS] = '{
		'{0, 0, 1, 1}, '{0, 1, 2, 3}, '{0, 0, 0, 0}, '{2, 0, 1, 2},
		'{0, 1, 1, 1}, '{0, 1, 2, 0}, '{1, 2, 0, 1}, '{0, 0, 1, 1}};

	// Lowest filled row offset per column of the shape
	localparam ofs_t COL_BOTTOM [8][4] = '{
		'{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{2, 0, 0, 0},
		'{0, 1, 1, 0}, '{0, 0, 0, 0}, '{1, 0, 0, 0}, '{0, 0, 1, 0}};

	localparam logic [2:0] SHAPE_WIDTH [8] = '{2, 1, 4, 2, 3, 2, 2, 3};

endpackage

`default_nettype wire

// ==== logic/tetris_defines.svh ====
/*
 * Board geometry and game length for the six-column block engine
 */
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// ----------------------------------------
// Board geometry
// ----------------------------------------

// Columns across the well
`define TETRIS_COLS 6

// Stored rows, row 1 is the floor
`define TETRIS_ROWS 16

// Rows sent out in a report, the rest is overflow
`define TETRIS_VISIBLE 12

// ----------------------------------------
// Game and piece sizes
// ----------------------------------------

`define TETRIS_PIECES_PER_GAME 16
`define TETRIS_PIECE_CELLS 4

`endif

// ==== logic/tetris_game.sv ====
/*
 * Top level of the block engine: round sequencer, score, fail and report
 */
`timescale 1ns/1ps
`default_nettype none
`include "tetris_defines.svh"

module tetris_game (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input piece_pkg::shape_t tetromino,
	input logic [2:0] position,
	output logic score_valid,
	output logic tetris_valid,
	output logic [3:0] score,
	output logic fail,
	output logic [`TETRIS_VISIBLE*`TETRIS_COLS-1:0] tetris
);
	import piece_pkg::*;
	import board_pkg::*;

	typedef enum logic [2:0] {IDLE, LAND, PLACE, SETTLE, CLEAR, REPORT} state_t;

	state_t state, state_nxt;
	shape_t shape_q;
	logic [2:0] pos_q;
	piece_cells_t cells, cells_q;
	heights_t heights;
	board_t board;
	logic [2:0] clear_count;
	logic [4:0] round_cnt;
	logic [3:0] score_acc;
	logic fail_now, game_clear;
	report_t report_q;
	logic report_valid;

	// ----------------------------------------
	// Round sequencer
	// ----------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (in_valid) state_nxt = LAND;
			LAND:    state_nxt = PLACE;
			PLACE:   state_nxt = SETTLE;
			SETTLE:  state_nxt = (clear_count != 3'd0) ? CLEAR : REPORT;
			CLEAR:   state_nxt = REPORT;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Piece latch and landed cells
	always_ff @(posedge clk) begin
		if (state == IDLE && in_valid) begin
			shape_q <= tetromino;
			pos_q <= position;
		end
		if (state == LAND)
			cells_q <= cells;
	end

	column_height column_height_i (.clk, .rst_n, .board, .heights);

	piece_drop piece_drop_i (.heights, .shape(shape_q), .position(pos_q), .cells);

	board_store board_store_i (
		.clk,
		.rst_n,
		.cells(cells_q),
		.place(state == PLACE),
		.settle(state == SETTLE),
		.compact(state == CLEAR),
		.game_clear,
		.board,
		.clear_count
	);

	// ----------------------------------------
	// Score, fail and game end
	// ----------------------------------------

	// Anything left above the visible rows after clearing
	assign fail_now = |board[`TETRIS_ROWS:`TETRIS_VISIBLE+1];
	assign game_clear = (state == REPORT)
		&& (fail_now || round_cnt == 5'(`TETRIS_PIECES_PER_GAME));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_cnt <= '0;
			score_acc <= '0;
		end else if (game_clear) begin
			round_cnt <= '0;
			score_acc <= '0;
		end else begin
			if (state == IDLE && in_valid)
				round_cnt <= round_cnt + 5'd1;
			if (state == SETTLE)
				score_acc <= score_acc + {1'b0, clear_count};
		end
	end

	// Report stays zero outside its pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			report_q <= '0;
			report_valid <= 1'b0;
		end else if (state == REPORT) begin
			report_q.tetris <= board[`TETRIS_VISIBLE:1];
			report_q.score <= score_acc;
			report_q.fail <= fail_now;
			report_valid <= 1'b1;
		end else begin
			report_q <= '0;
			report_valid <= 1'b0;
		end
	end

	assign score_valid = report_valid;
	assign tetris_valid = report_valid;
	assign score = report_q.score;
	assign fail = report_q.fail;
	assign tetris = report_q.tetris;

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> state == IDLE);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/piece_pkg.sv
logic/board_pkg.sv
logic/column_height.sv
logic/piece_drop.sv
logic/board_store.sv
logic/tetris_game.sv
verification/tb_clock.sv
verification/tetris_tb.sv

// ==== verification/tb_clock.sv ====
/*
 * Testbench clock and reset source, 4 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Reset released on a rising edge, after the hold time
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/tetris_tb.sv ====
/*
 * Testbench of the block engine with a board and score reference model
 */
`timescale 1ns/1ps
`default_nettype none
`include "tetris_defines.svh"

module tetris_tb;
	import board_pkg::*;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [2:0] tetromino;
	logic [2:0] position;
	logic score_valid;
	logic tetris_valid;
	logic [3:0] score;
	logic fail;
	logic [`TETRIS_VISIBLE*`TETRIS_COLS-1:0] tetris;

	// Reference state
	logic [`TETRIS_COLS-1:0] ref_board [1:`TETRIS_ROWS];
	logic [3:0] ref_score;
	int ref_count;

	report_t exp_q [$];
	report_t exp_rep;
	int reports_seen;
	int checks;
	int errors;
	bit timed_out;
	logic [3:0] last_score;
	logic last_fail;
	logic [`TETRIS_VISIBLE*`TETRIS_COLS-1:0] last_tetris;
	int unsigned seed_val;

	tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

	tetris_game tetris_game_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.tetromino(tetromino),
		.position(position),
		.score_valid(score_valid),
		.tetris_valid(tetris_valid),
		.score(score),
		.fail(fail),
		.tetris(tetris)
	);

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	// Nibble r holds row offset r, bit c is column offset c
	function automatic logic [15:0] shape_bits(input logic [2:0] shape);
		case (shape)
			3'd0: return {4'b0000, 4'b0000, 4'b0011, 4'b0011};
			3'd1: return {4'b0001, 4'b0001, 4'b0001, 4'b0001};
			3'd2: return {4'b0000, 4'b0000, 4'b0000, 4'b1111};
			3'd3: return {4'b0000, 4'b0011, 4'b0010, 4'b0010};
			3'd4: return {4'b0000, 4'b0000, 4'b0111, 4'b0001};
			3'd5: return {4'b0000, 4'b0001, 4'b0001, 4'b0011};
			3'd6: return {4'b0000, 4'b0001, 4'b0011, 4'b0010};
			default: return {4'b0000, 4'b0000, 4'b0110, 4'b0011};
		endcase
	endfunction

	function automatic int shape_width(input logic [2:0] shape);
		logic [15:0] bits;
		int w;
		bits = shape_bits(shape);
		w = 0;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				if (bits[r*4+c] && c + 1 > w)
					w = c + 1;
		return w;
	endfunction

	function automatic report_t predict_report(input logic [2:0] shape, input int pos);
		logic [15:0] bits;
		logic [`TETRIS_COLS-1:0] kept [1:`TETRIS_ROWS];
		int h [`TETRIS_COLS];
		int base;
		int dst;
		int cleared;
		logic over;
		report_t rep;
		bits = shape_bits(shape);
		for (int c = 0; c < `TETRIS_COLS; c++) begin
			h[c] = 0;
			for (int r = 1; r <= `TETRIS_ROWS; r++)
				if (ref_board[r][c])
					h[c] = r;
		end
		// Lowest base where every cell sits above its column
		base = 0;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				if (bits[r*4+c] && h[pos+c] - r + 1 > base)
					base = h[pos+c] - r + 1;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				if (bits[r*4+c])
					ref_board[base+r][pos+c] = 1'b1;
		dst = 1;
		cleared = 0;
		for (int r = 1; r <= `TETRIS_ROWS; r++)
			kept[r] = '0;
		for (int r = 1; r <= `TETRIS_ROWS; r++) begin
			if (&ref_board[r]) begin
				cleared++;
			end else begin
				kept[dst] = ref_board[r];
				dst++;
			end
		end
		over = 1'b0;
		for (int r = 1; r <= `TETRIS_ROWS; r++) begin
			ref_board[r] = kept[r];
			if (r > `TETRIS_VISIBLE && kept[r] != '0)
				over = 1'b1;
		end
		ref_score = ref_score + 4'(cleared);
		rep = '0;
		for (int r = 1; r <= `TETRIS_VISIBLE; r++)
			rep.tetris[(r-1)*`TETRIS_COLS +: `TETRIS_COLS] = ref_board[r];
		rep.score = ref_score;
		rep.fail = over;
		ref_count++;
		// Game over wipes the board for the next piece
		if (over || ref_count == `TETRIS_PIECES_PER_GAME) begin
			for (int r = 1; r <= `TETRIS_ROWS; r++)
				ref_board[r] = '0;
			ref_score = '0;
			ref_count = 0;
		end
		return rep;
	endfunction

	// ----------------------------------------
	// Compare process
	// ----------------------------------------

	always @(negedge clk) begin
		checks++;
		if (score_valid) begin
			if (exp_q.size() == 0) begin
				$display("Report arrived at %0t ns with no piece outstanding", $time);
				errors++;
			end else begin
				exp_rep = exp_q.pop_front();
				if (tetris_valid !== 1'b1) begin
					$display("[FAIL] t=%0t: tetris_valid low during score_valid", $time);
					errors++;
				end
				if (tetris !== exp_rep.tetris) begin
					$display("[FAIL] t=%0t: tetris %h, expected %h", $time, tetris,
						exp_rep.tetris);
					errors++;
				end
				if (score !== exp_rep.score) begin
					$display("[FAIL] t=%0t: score %0d, expected %0d", $time, score,
						exp_rep.score);
					errors++;
				end
				if (fail !== exp_rep.fail) begin
					$display("[FAIL] t=%0t: fail %b, expected %b", $time, fail, exp_rep.fail);
					errors++;
				end
			end
			last_score = score;
			last_fail = fail;
			last_tetris = tetris;
			reports_seen++;
		end else if (tetris_valid !== 1'b0 || score !== '0 || fail !== 1'b0
				|| tetris !== '0) begin
			$display("[FAIL] t=%0t: outputs not zero outside the report pulse", $time);
			errors++;
		end
	end

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------

	task automatic end_run();
		$display("checks=%0d errors=%0d timeout=%0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic drop_piece(input logic [2:0] shape, input int pos);
		int seen0;
		int waited;
		seen0 = reports_seen;
		@(negedge clk);
		in_valid = 1'b1;
		tetromino = shape;
		position = 3'(pos);
		exp_q.push_back(predict_report(shape, pos));
		@(negedge clk);
		in_valid = 1'b0;
		waited = 0;
		while (reports_seen == seen0) begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				$display("Timeout at %0t ns: no score_valid after a piece", $time);
				timed_out = 1'b1;
				end_run();
			end
		end
	endtask

	// Vertical bars across the columns until the game ends
	task automatic start_new_game();
		int col;
		col = 0;
		while (ref_count != 0) begin
			drop_piece(3'd1, col);
			col = (col + 1) % `TETRIS_COLS;
		end
	endtask

	task automatic note_mismatch(input string what, input logic [71:0] got,
			input logic [71:0] expected);
		$display("[FAIL] t=%0t: %s %h, expected %h", $time, what, got, expected);
		errors++;
	endtask

	task automatic test_done(input string name, input int errors_before);
		$display("test %s: %0d new errors", name, errors - errors_before);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		int e0;
		int waited;
		logic [2:0] shp;
		in_valid = 1'b0;
		tetromino = '0;
		position = '0;
		checks = 0;
		errors = 0;
		reports_seen = 0;
		timed_out = 1'b0;
		ref_score = '0;
		ref_count = 0;
		for (int r = 1; r <= `TETRIS_ROWS; r++)
			ref_board[r] = '0;
		seed_val = $urandom(32'h121e0f53);

		// Outputs quiet through reset and idle cycles
		e0 = errors;
		waited = 0;
		while (!rst_n) begin
			@(negedge clk);
			waited++;
			if (waited > 10) begin
				$display("Timeout: reset never released");
				timed_out = 1'b1;
				end_run();
			end
		end
		repeat (4) @(negedge clk);
		test_done("reset_idle", e0);

		e0 = errors;
		start_new_game();
		drop_piece(3'd1, 0);
		drop_piece(3'd0, 3);
		for (int s = 0; s < 8; s++)
			drop_piece(3'(s), s % (7 - shape_width(3'(s))));
		test_done("shapes_on_stacks", e0);

		// One row, then two rows at once
		e0 = errors;
		start_new_game();
		drop_piece(3'd2, 0);
		drop_piece(3'd1, 4);
		drop_piece(3'd1, 5);
		if (last_score !== 4'd1)
			note_mismatch("score after one row", 72'(last_score), 72'd1);
		drop_piece(3'd0, 0);
		drop_piece(3'd0, 2);
		if (last_score !== 4'd3)
			note_mismatch("score after two rows", 72'(last_score), 72'd3);
		if (last_tetris !== 72'h30)
			note_mismatch("board after two rows", last_tetris, 72'h30);
		test_done("line_clear", e0);

		e0 = errors;
		start_new_game();
		// Two single-row clears so the game score is 2 when it fails
		drop_piece(3'd1, 4);
		drop_piece(3'd1, 5);
		drop_piece(3'd2, 0);
		drop_piece(3'd2, 0);
		repeat (4) drop_piece(3'd1, 0);
		if (last_fail !== 1'b1)
			note_mismatch("fail on overflow", 72'(last_fail), 72'd1);
		drop_piece(3'd2, 0);
		if (last_score > 4'd1)
			note_mismatch("score after fail", 72'(last_score), 72'd1);
		if (last_tetris !== 72'h0f)
			note_mismatch("board after fail", last_tetris, 72'h0f);
		test_done("overflow_fail", e0);

		// Full game of bars, then a fresh board
		e0 = errors;
		start_new_game();
		for (int i = 0; i < `TETRIS_PIECES_PER_GAME; i++)
			drop_piece(3'd1, i % `TETRIS_COLS);
		drop_piece(3'd0, 0);
		if (last_score !== 4'd0)
			note_mismatch("score in new game", 72'(last_score), 72'd0);
		if (last_tetris !== 72'hc3)
			note_mismatch("board in new game", last_tetris, 72'hc3);
		test_done("game_length", e0);

		e0 = errors;
		for (int i = 0; i < 200; i++) begin
			shp = 3'($urandom % 8);
			drop_piece(shp, int'($urandom % (7 - shape_width(shp))));
		end
		test_done("random_pieces", e0);

		end_run();
	end

endmodule

`default_nettype wire
